/* verilog.f */
source/wb_pkg.sv
source/wb_decode.sv
source/cp0_regs.sv
source/tlb_array.sv
source/wb_result.sv
source/wb_subsystem.sv
tests/wb_subsystem_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = wb_subsystem_tb
FILELIST  = verilog.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "** PASS **"

clean:
	rm -rf obj_dir

/* tests/wb_subsystem_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_subsystem_tb import wb_pkg::*; ();

    localparam int TLB_NUM = 16;
    localparam int IDX_W = $clog2(TLB_NUM);
    localparam int N_ITEMS = 2000;
    localparam int MAX_CYCLES = N_ITEMS + 100;
    localparam logic [31:0] EXC_ENTRY = 32'hbfc00380;

    // ExcCode per source, bit 0 first
    localparam logic [4:0] CODE_TABLE [12] = '{
        5'd0, 5'd4, 5'd2, 5'd10, 5'd12, 5'd8,
        5'd9, 5'd4, 5'd5, 5'd2, 5'd3, 5'd1
    };
    localparam logic [11:0] BADVADDR_SRC = 12'b1111_1000_0110;
    localparam logic [7:0] CP0_ADDRS [8] = '{
        CP0_INDEX, CP0_ENTRYLO0, CP0_ENTRYLO1, CP0_BADVADDR,
        CP0_ENTRYHI, CP0_STATUS, CP0_CAUSE, CP0_EPC
    };

    logic       clk;
    logic       reset;
    logic       ms_valid;
    ms_bundle_t ms_bundle;
    logic       flush;
    logic [5:0] ext_int;
    rf_write_t  rf_write;
    bypass_t    bypass;
    flush_t     flush_req;
    logic       int_happen;
    logic       entryhi_hazard;

    int unsigned cycles = 0;

    // reference copy of CP0, as read by mfc0
    logic [31:0] m_index;
    logic [31:0] m_entryhi;
    logic [31:0] m_entrylo0;
    logic [31:0] m_entrylo1;
    logic [31:0] m_badvaddr;
    logic [31:0] m_epc;
    logic [31:0] m_status;
    logic [31:0] m_cause;

    // reference TLB, page words kept with g clear
    logic [18:0] t_vpn2 [TLB_NUM];
    logic [7:0]  t_asid [TLB_NUM];
    logic        t_g [TLB_NUM];
    logic [31:0] t_lo0 [TLB_NUM];
    logic [31:0] t_lo1 [TLB_NUM];

    ms_bundle_t held;
    logic       held_valid;
    ms_bundle_t pend;
    logic       pend_valid;
    logic       pend_flush;
    logic [5:0] pend_ext;

    wb_subsystem #(.TLB_NUM(TLB_NUM)) wb_subsystem_i (
        .clk           (clk),
        .reset         (reset),
        .ms_valid      (ms_valid),
        .ms_bundle     (ms_bundle),
        .flush         (flush),
        .ext_int       (ext_int),
        .rf_write      (rf_write),
        .bypass        (bypass),
        .flush_req     (flush_req),
        .int_happen    (int_happen),
        .entryhi_hazard(entryhi_hazard)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic reset_model();
        m_index    = '0;
        m_entryhi  = '0;
        m_entrylo0 = '0;
        m_entrylo1 = '0;
        m_badvaddr = '0;
        m_epc      = '0;
        m_status   = 32'h0040_0000;
        m_cause    = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            t_vpn2[i] = '0;
            t_asid[i] = '0;
            t_g[i]    = 1'b0;
            t_lo0[i]  = '0;
            t_lo1[i]  = '0;
        end
        held       = '0;
        held_valid = 1'b0;
    endtask

    function automatic logic [31:0] read_cp0(input logic [7:0] addr);
        case (addr)
            CP0_INDEX:    return m_index;
            CP0_ENTRYLO0: return m_entrylo0;
            CP0_ENTRYLO1: return m_entrylo1;
            CP0_BADVADDR: return m_badvaddr;
            CP0_ENTRYHI:  return m_entryhi;
            CP0_STATUS:   return m_status;
            CP0_CAUSE:    return m_cause;
            CP0_EPC:      return m_epc;
            default:      return 32'd0;
        endcase
    endfunction

    task automatic write_cp0(input logic [7:0] addr, input logic [31:0] d);
        case (addr)
            CP0_INDEX:    m_index[IDX_W-1:0] = d[IDX_W-1:0];
            CP0_ENTRYLO0: m_entrylo0 = d & 32'h03ff_ffff;
            CP0_ENTRYLO1: m_entrylo1 = d & 32'h03ff_ffff;
            CP0_ENTRYHI:  m_entryhi = d & 32'hffff_e0ff;
            CP0_STATUS:   m_status = (d & 32'h0000_ff03) | 32'h0040_0000;
            CP0_CAUSE:    m_cause[9:8] = d[9:8];
            CP0_EPC:      m_epc = d;
            default:      ;
        endcase
    endtask

    // effect of the held item at the edge that ends its cycle
    task automatic commit_held();
        logic             found;
        int               src;
        logic [IDX_W-1:0] idx;
        found = 1'b0;
        src   = 0;
        idx   = m_index[IDX_W-1:0];
        for (int i = 0; i < EXC_NUM; i++) begin
            if (held.exc[i] && !found) begin
                found = 1'b1;
                src   = i;
            end
        end
        if (!held_valid) begin
            found = 1'b0;
        end else if (found) begin
            if (!m_status[1]) begin
                m_epc = held.bd ? held.pc - 32'd4 : held.pc;
            end
            m_status[1]  = 1'b1;
            m_cause[31]  = held.bd;
            m_cause[6:2] = CODE_TABLE[src];
            if (BADVADDR_SRC[src]) begin
                m_badvaddr = held.badvaddr;
            end
        end else if (held.eret) begin
            m_status[1] = 1'b0;
        end else if (held.cp0_wen) begin
            write_cp0(held.cp0_addr, held.alu_result);
        end else if (held.inst_tlbp) begin
            // several matches resolve to the highest index
            m_index[31] = 1'b1;
            for (int i = 0; i < TLB_NUM; i++) begin
                if (t_vpn2[i] == m_entryhi[31:13] &&
                    (t_g[i] || t_asid[i] == m_entryhi[7:0])) begin
                    m_index = {1'b0, {(31 - IDX_W){1'b0}}, IDX_W'(i)};
                end
            end
        end else if (held.inst_tlbr) begin
            m_entryhi  = {t_vpn2[idx], 5'd0, t_asid[idx]};
            m_entrylo0 = t_lo0[idx] | {31'd0, t_g[idx]};
            m_entrylo1 = t_lo1[idx] | {31'd0, t_g[idx]};
        end else if (held.inst_tlbwi) begin
            t_vpn2[idx] = m_entryhi[31:13];
            t_asid[idx] = m_entryhi[7:0];
            t_g[idx]    = m_entrylo0[0] & m_entrylo1[0];
            t_lo0[idx]  = {m_entrylo0[31:1], 1'b0};
            t_lo1[idx]  = {m_entrylo1[31:1], 1'b0};
        end
    endtask

    task automatic advance_stage();
        m_cause[15:10] = pend_ext;
        held       = pend;
        held_valid = pend_valid && !pend_flush;
    endtask

    task automatic check_outputs();
        logic        has_exc;
        logic        int_exp;
        logic        flush_exp;
        logic        tflush_exp;
        logic [3:0]  we_exp;
        logic [31:0] data_exp;
        logic [31:0] target_exp;
        logic        hazard_exp;
        int_exp = m_status[0] && !m_status[1] && ((m_cause[15:8] & m_status[15:8]) != 8'd0);
        check_value("int_happen", 32'(int_happen), 32'(int_exp));
        has_exc    = held.exc != '0;
        we_exp     = (held_valid && !has_exc) ? held.gr_we : 4'd0;
        data_exp   = held.res_from_cp0 ? read_cp0(held.cp0_addr) : held.alu_result;
        flush_exp  = held_valid && (has_exc || held.eret);
        tflush_exp = held_valid && held.tlb_flush;
        hazard_exp = held_valid && ((held.cp0_wen && held.cp0_addr == CP0_ENTRYHI) ||
                                    held.inst_tlbr);
        target_exp = has_exc ? EXC_ENTRY : (held.eret ? m_epc : held.pc);
        check_value("rf_write.we", 32'(rf_write.we), 32'(we_exp));
        check_value("bypass.valid", 32'(bypass.valid), 32'(held_valid));
        check_value("bypass.we", 32'(bypass.we), 32'(we_exp));
        check_value("flush_req.flush", 32'(flush_req.flush), 32'(flush_exp));
        check_value("flush_req.tlb_flush", 32'(flush_req.tlb_flush), 32'(tflush_exp));
        check_value("entryhi_hazard", 32'(entryhi_hazard), 32'(hazard_exp));
        if (held_valid) begin
            check_value("rf_write.addr", 32'(rf_write.addr), 32'(held.dest));
            check_value("rf_write.data", rf_write.data, data_exp);
            check_value("bypass.dest", 32'(bypass.dest), 32'(held.dest));
            check_value("bypass.data", bypass.data, data_exp);
        end
        if (flush_exp || tflush_exp) begin
            check_value("flush_req.target", flush_req.target, target_exp);
        end
    endtask

    task automatic drive_next();
        logic [31:0] rnd;
        logic [31:0] kind;
        logic [3:0]  src;
        cp0_word_u   w;
        ms_bundle_t  it;
        it = '0;
        rnd = $urandom;
        it.pc = {rnd[31:2], 2'b00};
        it.alu_result = $urandom;
        it.badvaddr = $urandom;
        rnd = $urandom;
        it.dest = rnd[4:0];
        it.gr_we = rnd[8:5];
        it.bd = rnd[9] & rnd[10];
        it.cp0_addr = CP0_ADDRS[rnd[13:11]];
        kind = $urandom % 100;
        if (kind < 10) begin
            it.gr_we = 4'd0;
            it.inst_tlbp = kind < 4;
            it.inst_tlbr = kind >= 4 && kind < 7;
            it.inst_tlbwi = kind >= 7;
            it.tlb_flush = rnd[14];
        end else if (kind < 35) begin
            it.gr_we = 4'd0;
            it.cp0_wen = 1'b1;
            w.raw = it.alu_result;
            // few vpn2/asid values so probes hit
            if (it.cp0_addr == CP0_ENTRYHI) begin
                w.hi.vpn2 = {17'd0, rnd[16:15]};
                w.hi.asid = {6'd0, rnd[18:17]};
            end
            it.alu_result = w.raw;
        end else if (kind < 55) begin
            it.res_from_cp0 = 1'b1;
        end else if (kind < 60) begin
            it.gr_we = 4'd0;
            it.eret = 1'b1;
        end
        rnd = $urandom;
        if (rnd % 100 < 6) begin
            src = 4'((rnd >> 8) % 12);
            it.exc[src] = 1'b1;
            if (rnd[20]) begin
                src = 4'((rnd >> 21) % 12);
                it.exc[src] = 1'b1;
            end
        end
        rnd = $urandom;
        pend_valid = (rnd % 100) >= 20;
        pend_flush = ((rnd >> 8) % 100) < 6;
        if (rnd[31:28] == 4'd0) begin
            pend_ext = rnd[21:16];
        end
        pend = it;
        ms_valid  = pend_valid;
        ms_bundle = it;
        flush     = pend_flush;
        ext_int   = pend_ext;
    endtask

    initial begin
        logic [31:0] seed_state;
        clk        = 1'b0;
        reset      = 1'b1;
        ms_valid   = 1'b0;
        ms_bundle  = '0;
        flush      = 1'b0;
        ext_int    = '0;
        pend       = '0;
        pend_valid = 1'b0;
        pend_flush = 1'b0;
        pend_ext   = '0;
        seed_state = $urandom(32'he0384a5a);
        reset_model();
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int n = 0; n < N_ITEMS; n++) begin
            drive_next();
            @(posedge clk);
            #2;
            commit_held();
            advance_stage();
            check_outputs();
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* source/wb_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_subsystem import wb_pkg::*; #(
    parameter int TLB_NUM = TLB_NUM_DEFAULT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       ms_valid,
    input  ms_bundle_t ms_bundle,
    input  logic       flush,
    input  logic [5:0] ext_int,
    output rf_write_t  rf_write,
    output bypass_t    bypass,
    output flush_t     flush_req,
    output logic       int_happen,
    output logic       entryhi_hazard
);

    logic                       ws_valid;
    ms_bundle_t                 ws_item;
    cp0_ctrl_t                  cp0_ctrl;
    logic [31:0]                cp0_rdata;
    logic [31:0]                epc;
    entryhi_t                   entryhi;
    logic [$clog2(TLB_NUM)-1:0] tlb_index;
    tlb_entry_t                 tlbwi_entry;
    logic                       probe_hit;
    logic [$clog2(TLB_NUM)-1:0] probe_index;
    tlb_entry_t                 read_entry;

    wb_decode wb_decode_i (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .ms_valid (ms_valid),
        .ms_bundle(ms_bundle),
        .ws_valid (ws_valid),
        .ws_item  (ws_item),
        .cp0_ctrl (cp0_ctrl)
    );

    cp0_regs #(.TLB_NUM(TLB_NUM)) cp0_regs_i (
        .clk        (clk),
        .reset      (reset),
        .cp0_ctrl   (cp0_ctrl),
        .ext_int    (ext_int),
        .probe_hit  (probe_hit),
        .probe_index(probe_index),
        .read_entry (read_entry),
        .cp0_rdata  (cp0_rdata),
        .epc        (epc),
        .entryhi    (entryhi),
        .tlb_index  (tlb_index),
        .tlbwi_entry(tlbwi_entry),
        .int_happen (int_happen)
    );

    tlb_array #(.TLB_NUM(TLB_NUM)) tlb_array_i (
        .clk        (clk),
        .reset      (reset),
        .entryhi    (entryhi),
        .tlb_index  (tlb_index),
        .tlbwi_we   (cp0_ctrl.tlbwi),
        .tlbwi_entry(tlbwi_entry),
        .probe_hit  (probe_hit),
        .probe_index(probe_index),
        .read_entry (read_entry)
    );

    wb_result wb_result_i (
        .ws_valid      (ws_valid),
        .ws_item       (ws_item),
        .cp0_rdata     (cp0_rdata),
        .epc           (epc),
        .rf_write      (rf_write),
        .bypass        (bypass),
        .flush_req     (flush_req),
        .entryhi_hazard(entryhi_hazard)
    );

endmodule

`default_nettype wire

/* source/wb_result.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_result import wb_pkg::*; (
    input  logic        ws_valid,
    input  ms_bundle_t  ws_item,
    input  logic [31:0] cp0_rdata,
    input  logic [31:0] epc,
    output rf_write_t   rf_write,
    output bypass_t     bypass,
    output flush_t      flush_req,
    output logic        entryhi_hazard
);

    logic        has_exc;
    logic [31:0] final_result;
    logic [3:0]  rf_we;

    assign has_exc      = |ws_item.exc;
    assign final_result = ws_item.res_from_cp0 ? cp0_rdata : ws_item.alu_result;
    assign rf_we        = ws_item.gr_we & {4{ws_valid && !has_exc}};

    assign rf_write = '{we: rf_we, addr: ws_item.dest, data: final_result};

    // decode uses this for both stall and forwarding
    assign bypass = '{valid: ws_valid, we: rf_we, dest: ws_item.dest, data: final_result};

    always_comb begin
        flush_req.flush     = ws_valid && (has_exc || ws_item.eret);
        flush_req.tlb_flush = ws_valid && ws_item.tlb_flush;
        if (has_exc) begin
            flush_req.target = EXC_VECTOR;
        end else if (ws_item.eret) begin
            flush_req.target = epc;
        end else begin
            // refetch from the tlb instruction itself
            flush_req.target = ws_item.pc;
        end
    end

    assign entryhi_hazard = ws_valid && ((ws_item.cp0_wen && ws_item.cp0_addr == CP0_ENTRYHI) ||
                                         ws_item.inst_tlbr);

endmodule

`default_nettype wire

/* source/tlb_array.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_array import wb_pkg::*; #(
    parameter int TLB_NUM = TLB_NUM_DEFAULT
) (
    input  logic                       clk,
    input  logic                       reset,
    input  entryhi_t                   entryhi,
    input  logic [$clog2(TLB_NUM)-1:0] tlb_index,
    input  logic                       tlbwi_we,
    input  tlb_entry_t                 tlbwi_entry,
    output logic                       probe_hit,
    output logic [$clog2(TLB_NUM)-1:0] probe_index,
    output tlb_entry_t                 read_entry
);

    localparam int IDX_W = $clog2(TLB_NUM);

    tlb_entry_t entries [TLB_NUM];
    logic [TLB_NUM-1:0] match;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                entries[i] <= '0;
            end
        end else if (tlbwi_we) begin
            entries[tlb_index] <= tlbwi_entry;
        end
    end

    // global entries ignore asid
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            match[i] = (entries[i].vpn2 == entryhi.vpn2) &&
                       (entries[i].g || entries[i].asid == entryhi.asid);
        end
    end

    always_comb begin
        probe_index = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (match[i]) begin
                probe_index = IDX_W'(i);
            end
        end
    end

    assign probe_hit  = |match;
    assign read_entry = entries[tlb_index];

endmodule

`default_nettype wire

/* source/cp0_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_regs import wb_pkg::*; #(
    parameter int TLB_NUM = TLB_NUM_DEFAULT
) (
    input  logic                       clk,
    input  logic                       reset,
    input  cp0_ctrl_t                  cp0_ctrl,
    input  logic [5:0]                 ext_int,
    input  logic                       probe_hit,
    input  logic [$clog2(TLB_NUM)-1:0] probe_index,
    input  tlb_entry_t                 read_entry,
    output logic [31:0]                cp0_rdata,
    output logic [31:0]                epc,
    output entryhi_t                   entryhi,
    output logic [$clog2(TLB_NUM)-1:0] tlb_index,
    output tlb_entry_t                 tlbwi_entry,
    output logic                       int_happen
);

    localparam int IDX_W = $clog2(TLB_NUM);

    cp0_word_u wr_word;

    logic             index_p;
    logic [IDX_W-1:0] index_val;
    entrylo_t         entrylo0;
    entrylo_t         entrylo1;
    logic [31:0]      badvaddr;
    logic [7:0]       status_im;
    logic             status_exl;
    logic             status_ie;
    logic             cause_bd;
    logic [5:0]       cause_ip_hw;
    logic [1:0]       cause_ip_sw;
    logic [4:0]       cause_exc_code;

    assign wr_word.raw = cp0_ctrl.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            index_p        <= 1'b0;
            index_val      <= '0;
            entryhi        <= '0;
            entrylo0       <= '0;
            entrylo1       <= '0;
            badvaddr       <= '0;
            epc            <= '0;
            status_im      <= '0;
            status_exl     <= 1'b0;
            status_ie      <= 1'b0;
            cause_bd       <= 1'b0;
            cause_ip_hw    <= '0;
            cause_ip_sw    <= '0;
            cause_exc_code <= '0;
        end else begin
            cause_ip_hw <= ext_int;
            if (cp0_ctrl.exc_take) begin
                status_exl     <= 1'b1;
                cause_exc_code <= cp0_ctrl.exc_code;
                cause_bd       <= cp0_ctrl.bd;
                // nested exception keeps the first return address
                if (!status_exl) begin
                    epc <= cp0_ctrl.bd ? cp0_ctrl.pc - 32'd4 : cp0_ctrl.pc;
                end
                if (cp0_ctrl.badvaddr_wen) begin
                    badvaddr <= cp0_ctrl.badvaddr;
                end
            end else if (cp0_ctrl.eret) begin
                status_exl <= 1'b0;
            end else if (cp0_ctrl.cp0_wen) begin
                case (cp0_ctrl.cp0_addr)
                    CP0_INDEX: index_val <= wr_word.raw[IDX_W-1:0];
                    CP0_ENTRYHI: begin
                        entryhi.vpn2 <= wr_word.hi.vpn2;
                        entryhi.asid <= wr_word.hi.asid;
                    end
                    CP0_ENTRYLO0: entrylo0 <= '{zeros: '0, pfn: wr_word.lo.pfn,
                        c: wr_word.lo.c, d: wr_word.lo.d, v: wr_word.lo.v, g: wr_word.lo.g};
                    CP0_ENTRYLO1: entrylo1 <= '{zeros: '0, pfn: wr_word.lo.pfn,
                        c: wr_word.lo.c, d: wr_word.lo.d, v: wr_word.lo.v, g: wr_word.lo.g};
                    CP0_STATUS: begin
                        status_im  <= wr_word.raw[15:8];
                        status_exl <= wr_word.raw[1];
                        status_ie  <= wr_word.raw[0];
                    end
                    CP0_CAUSE: cause_ip_sw <= wr_word.raw[9:8];
                    CP0_EPC: epc <= wr_word.raw;
                    default: ;
                endcase
            end else if (cp0_ctrl.tlbp) begin
                // index field left alone on a miss
                index_p <= !probe_hit;
                if (probe_hit) begin
                    index_val <= probe_index;
                end
            end else if (cp0_ctrl.tlbr) begin
                entryhi  <= '{vpn2: read_entry.vpn2, zeros: '0, asid: read_entry.asid};
                entrylo0 <= '{zeros: '0, pfn: read_entry.pfn0, c: read_entry.c0,
                    d: read_entry.d0, v: read_entry.v0, g: read_entry.g};
                entrylo1 <= '{zeros: '0, pfn: read_entry.pfn1, c: read_entry.c1,
                    d: read_entry.d1, v: read_entry.v1, g: read_entry.g};
            end
        end
    end

    always_comb begin
        case (cp0_ctrl.cp0_addr)
            CP0_INDEX:    cp0_rdata = {index_p, {(31 - IDX_W){1'b0}}, index_val};
            CP0_ENTRYLO0: cp0_rdata = entrylo0;
            CP0_ENTRYLO1: cp0_rdata = entrylo1;
            CP0_BADVADDR: cp0_rdata = badvaddr;
            CP0_ENTRYHI:  cp0_rdata = entryhi;
            // BEV hardwired at bit 22
            CP0_STATUS:   cp0_rdata = {9'd0, 1'b1, 6'd0, status_im, 6'd0, status_exl, status_ie};
            CP0_CAUSE:    cp0_rdata = {cause_bd, 15'd0, cause_ip_hw, cause_ip_sw, 1'b0,
                                       cause_exc_code, 2'b00};
            CP0_EPC:      cp0_rdata = epc;
            default:      cp0_rdata = '0;
        endcase
    end

    assign tlb_index = index_val;

    assign tlbwi_entry = '{vpn2: entryhi.vpn2, asid: entryhi.asid, g: entrylo0.g & entrylo1.g,
                           pfn0: entrylo0.pfn, c0: entrylo0.c, d0: entrylo0.d, v0: entrylo0.v,
                           pfn1: entrylo1.pfn, c1: entrylo1.c, d1: entrylo1.d, v1: entrylo1.v};

    assign int_happen = status_ie && !status_exl && |({cause_ip_hw, cause_ip_sw} & status_im);

endmodule

`default_nettype wire

/* source/wb_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_decode import wb_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       ms_valid,
    input  ms_bundle_t ms_bundle,
    output logic       ws_valid,
    output ms_bundle_t ws_item,
    output cp0_ctrl_t  cp0_ctrl
);

    logic       has_exc;
    logic       commit;
    logic [4:0] exc_code;
    logic       badvaddr_sel;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_valid;
        end
        if (ms_valid) begin
            ws_item <= ms_bundle;
        end
    end

    // highest priority source is the lowest bit
    always_comb begin
        exc_code     = '0;
        badvaddr_sel = 1'b0;
        for (int i = EXC_NUM - 1; i >= 0; i--) begin
            if (ws_item.exc[i]) begin
                exc_code     = EXC_CODE[i];
                badvaddr_sel = EXC_BADVADDR[i];
            end
        end
    end

    assign has_exc = |ws_item.exc;
    // side effects only for a valid item without exception
    assign commit  = ws_valid && !has_exc;

    always_comb begin
        cp0_ctrl.cp0_wen      = commit && ws_item.cp0_wen;
        cp0_ctrl.cp0_addr     = ws_item.cp0_addr;
        cp0_ctrl.wdata        = ws_item.alu_result;
        cp0_ctrl.exc_take     = ws_valid && has_exc;
        cp0_ctrl.exc_code     = exc_code;
        cp0_ctrl.badvaddr_wen = ws_valid && badvaddr_sel;
        cp0_ctrl.badvaddr     = ws_item.badvaddr;
        cp0_ctrl.pc           = ws_item.pc;
        cp0_ctrl.bd           = ws_item.bd;
        cp0_ctrl.eret         = commit && ws_item.eret;
        cp0_ctrl.tlbp         = commit && ws_item.inst_tlbp;
        cp0_ctrl.tlbr         = commit && ws_item.inst_tlbr;
        cp0_ctrl.tlbwi        = commit && ws_item.inst_tlbwi;
    end

endmodule

`default_nettype wire

/* source/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    localparam int TLB_NUM_DEFAULT = 16;
    localparam int EXC_NUM = 12;

    // bit 0 wins when several are set
    typedef logic [EXC_NUM-1:0] exc_vec_t;

    // int, AdEL(if), TLBL(if), RI, Ov, Sys, Bp, AdEL, AdES, TLBL, TLBS, Mod
    localparam logic [4:0] EXC_CODE [EXC_NUM] = '{
        5'd0, 5'd4, 5'd2, 5'd10, 5'd12, 5'd8,
        5'd9, 5'd4, 5'd5, 5'd2, 5'd3, 5'd1
    };

    // sources that latch BadVAddr
    localparam exc_vec_t EXC_BADVADDR = 12'b1111_1000_0110;

    localparam logic [31:0] EXC_VECTOR = 32'hbfc00380;

    // {reg number, select}
    localparam logic [7:0] CP0_INDEX    = {5'd0, 3'd0};
    localparam logic [7:0] CP0_ENTRYLO0 = {5'd2, 3'd0};
    localparam logic [7:0] CP0_ENTRYLO1 = {5'd3, 3'd0};
    localparam logic [7:0] CP0_BADVADDR = {5'd8, 3'd0};
    localparam logic [7:0] CP0_ENTRYHI  = {5'd10, 3'd0};
    localparam logic [7:0] CP0_STATUS   = {5'd12, 3'd0};
    localparam logic [7:0] CP0_CAUSE    = {5'd13, 3'd0};
    localparam logic [7:0] CP0_EPC      = {5'd14, 3'd0};

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic [4:0]  dest;
        logic [3:0]  gr_we;
        logic        res_from_cp0;
        logic        cp0_wen;
        logic [7:0]  cp0_addr;
        logic        eret;
        exc_vec_t    exc;
        logic        bd;
        logic [31:0] badvaddr;
        logic        inst_tlbp;
        logic        inst_tlbr;
        logic        inst_tlbwi;
        logic        tlb_flush;
    } ms_bundle_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  zeros;
        logic [7:0]  asid;
    } entryhi_t;

    typedef struct packed {
        logic [5:0]  zeros;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } entrylo_t;

    typedef union packed {
        logic [31:0] raw;
        entryhi_t    hi;
        entrylo_t    lo;
    } cp0_word_u;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic        cp0_wen;
        logic [7:0]  cp0_addr;
        logic [31:0] wdata;
        logic        exc_take;
        logic [4:0]  exc_code;
        logic        badvaddr_wen;
        logic [31:0] badvaddr;
        logic [31:0] pc;
        logic        bd;
        logic        eret;
        logic        tlbp;
        logic        tlbr;
        logic        tlbwi;
    } cp0_ctrl_t;

    typedef struct packed {
        logic [3:0]  we;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_write_t;

    typedef struct packed {
        logic        valid;
        logic [3:0]  we;
        logic [4:0]  dest;
        logic [31:0] data;
    } bypass_t;

    typedef struct packed {
        logic        flush;
        logic        tlb_flush;
        logic [31:0] target;
    } flush_t;

endpackage

`default_nettype wire
